// File: include/pitaya_defs.svh
// Pitaya data path definitions

`ifndef PITAYA_DEFS_SVH
`define PITAYA_DEFS_SVH

//////////////////////////////
// bus
//////////////////////////////

`define PITAYA_ADW 32 // address and data word

// region field sits at address bits 22..20
`define PITAYA_REGION_LSB 20

// read-only ID word, "PI" plus revision
`define PITAYA_ID 32'h5049_0001

//////////////////////////////
// samples and calibration
//////////////////////////////

`define PITAYA_SDW 14 // ADC and DAC sample width
`define PITAYA_GDW 16 // gain word, Q2.14

// fraction bits of the gain, 1.0 is 0x4000
`define PITAYA_GAIN_FRAC 14

`endif

// File: design/pitaya_bus_pkg.sv
// System bus types
`include "pitaya_defs.svh"

package pitaya_bus_pkg;

  // address or data word
  typedef logic [`PITAYA_ADW-1:0] bus_word_t;

  // region select, addr[22:20]
  typedef enum logic [2:0] {
    REGION_HK    = 3'd0, // housekeeping
    REGION_CALIB = 3'd1  // calibration
  } bus_region_e;         // 2..7 left unused

  // housekeeping offsets inside region 0
  typedef enum logic [`PITAYA_REGION_LSB-1:0] {
    HK_ID   = 'h00, // read-only
    HK_LOOP = 'h04, // digital loopback enable
    HK_LED  = 'h30
  } hk_reg_e;

  // calibration offsets inside region 1
  typedef enum logic [`PITAYA_REGION_LSB-1:0] {
    CAL_ADC_A_GAIN = 'h00, CAL_ADC_A_OFFS = 'h04,
    CAL_ADC_B_GAIN = 'h08, CAL_ADC_B_OFFS = 'h0C,
    CAL_DAC_A_GAIN = 'h10, CAL_DAC_A_OFFS = 'h14,
    CAL_DAC_B_GAIN = 'h18, CAL_DAC_B_OFFS = 'h1C
  } cal_reg_e;

endpackage

// File: design/pitaya_dsp_pkg.sv
// Sample and calibration types
`include "pitaya_defs.svh"

package pitaya_dsp_pkg;

  //////////////////////////////
  // stream data
  //////////////////////////////

  // two's complement sample, both directions
  typedef logic signed [`PITAYA_SDW-1:0] sample_t;

  //////////////////////////////
  // calibration
  //////////////////////////////

  // Q2.14, so +-2.0 full range
  typedef logic signed [`PITAYA_GDW-1:0] gain_t;

  // added after scaling, same width as a sample
  typedef logic signed [`PITAYA_SDW-1:0] offset_t;

  // one channel setting, 30 bits
  typedef struct packed {
    gain_t   gain;   // multiplier
    offset_t offset; // post-scale offset
  } cal_cfg_t;

endpackage

// File: design/sys_bus_if.sv
// System register bus
`timescale 1ns/1ps

interface sys_bus_if;

  // request, from the decoder
  pitaya_bus_pkg::bus_word_t addr;  // held for the whole access
  pitaya_bus_pkg::bus_word_t wdata; // full word writes only
  logic                      wen;   // one-cycle strobe
  logic                      ren;   // one-cycle strobe

  // response, from the slave
  pitaya_bus_pkg::bus_word_t rdata; // valid with ack
  logic                      err;   // valid with ack
  logic                      ack;

  // decoder side
  modport decoder (
    output addr,
    output wdata,
    output wen,
    output ren,
    input  rdata,
    input  err,
    input  ack
  );

  // register block side
  modport slave (
    input  addr,
    input  wdata,
    input  wen,
    input  ren,
    output rdata,
    output err,
    output ack
  );

endinterface

// File: design/sys_bus_decoder.sv
// System bus region decoder
`timescale 1ns/1ps
`include "pitaya_defs.svh"

module sys_bus_decoder (
  input  logic                      adc_clk,
  input  logic                      top_rst,
  // master side
  input  pitaya_bus_pkg::bus_word_t m_addr_i,
  input  pitaya_bus_pkg::bus_word_t m_wdata_i,
  input  logic                      m_wen_i,
  input  logic                      m_ren_i,
  output pitaya_bus_pkg::bus_word_t m_rdata_o,
  output logic                      m_err_o,
  output logic                      m_ack_o,
  // slaves
  sys_bus_if.decoder                hk_bus,  // region 0
  sys_bus_if.decoder                cal_bus  // region 1
);

  pitaya_bus_pkg::bus_region_e region;
  logic                        sel_hk;
  logic                        sel_cal;

  // region only, offsets are left to the slaves
  assign region = pitaya_bus_pkg::bus_region_e'(
    m_addr_i[`PITAYA_REGION_LSB +: $bits(pitaya_bus_pkg::bus_region_e)]);

  assign sel_hk  = (region == pitaya_bus_pkg::REGION_HK);
  assign sel_cal = (region == pitaya_bus_pkg::REGION_CALIB);

  //////////////////////////////
  // request steering
  //////////////////////////////

  assign hk_bus.addr  = m_addr_i; // broadcast
  assign hk_bus.wdata = m_wdata_i;
  assign hk_bus.wen   = m_wen_i & sel_hk;
  assign hk_bus.ren   = m_ren_i & sel_hk;

  assign cal_bus.addr  = m_addr_i;
  assign cal_bus.wdata = m_wdata_i;
  assign cal_bus.wen   = m_wen_i & sel_cal;
  assign cal_bus.ren   = m_ren_i & sel_cal;

  //////////////////////////////
  // response mux
  //////////////////////////////

  // address is held until ack, so it can steer the response too
  always_comb
  begin
    m_rdata_o = '0;
    m_err_o   = 1'b0;
    m_ack_o   = m_wen_i | m_ren_i; // unused regions answer at once
    case (region)
      pitaya_bus_pkg::REGION_HK:
      begin
        m_rdata_o = hk_bus.rdata;
        m_err_o   = hk_bus.err;
        m_ack_o   = hk_bus.ack;
      end
      pitaya_bus_pkg::REGION_CALIB:
      begin
        m_rdata_o = cal_bus.rdata;
        m_err_o   = cal_bus.err;
        m_ack_o   = cal_bus.ack;
      end
      default: ; // zero data, no error
    endcase
  end

  // the master issues one kind of access at a time
  a_one_strobe : assert property (@(posedge adc_clk) disable iff (top_rst)
    !(m_wen_i && m_ren_i))
    else $error("sys bus: wen and ren high together");

endmodule

// File: design/housekeeping.sv
// Housekeeping registers
`timescale 1ns/1ps
`include "pitaya_defs.svh"

module housekeeping (
  input  logic        adc_clk,
  input  logic        top_rst,
  sys_bus_if.slave    bus,
  output logic        loop_en_o, // DAC to ADC digital loopback
  output logic [7:0]  led_o
);

  pitaya_bus_pkg::hk_reg_e   off;
  pitaya_bus_pkg::bus_word_t rd_val;
  logic                      hit;    // known offset

  assign off = pitaya_bus_pkg::hk_reg_e'(bus.addr[`PITAYA_REGION_LSB-1:0]);

  // read-back, zero-extended
  always_comb
  begin
    rd_val = '0;
    hit    = 1'b1;
    case (off)
      pitaya_bus_pkg::HK_ID:   rd_val = `PITAYA_ID;
      pitaya_bus_pkg::HK_LOOP: rd_val = pitaya_bus_pkg::bus_word_t'(loop_en_o);
      pitaya_bus_pkg::HK_LED:  rd_val = pitaya_bus_pkg::bus_word_t'(led_o);
      default:                 hit    = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
    begin
      loop_en_o <= 1'b0;
      led_o     <= '0;
    end
    else if (bus.wen)
    begin
      case (off)
        pitaya_bus_pkg::HK_LOOP: loop_en_o <= bus.wdata[0];
        pitaya_bus_pkg::HK_LED:  led_o     <= bus.wdata[7:0];
        default: ; // ID stays as is
      endcase
    end
  end

  // response one cycle after the strobe
  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
    begin
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
      bus.rdata <= '0;
    end
    else
    begin
      bus.ack   <= bus.wen | bus.ren;
      bus.err   <= (bus.wen | bus.ren) & ~hit;
      bus.rdata <= (bus.ren && hit) ? rd_val : '0;
    end
  end

  // holds while the master waits for each ack
  a_ack_pulse : assert property (@(posedge adc_clk) disable iff (top_rst)
    bus.ack |=> !bus.ack)
    else $error("housekeeping: ack longer than one cycle");

endmodule

// File: design/calib_regs.sv
// Calibration registers
`timescale 1ns/1ps
`include "pitaya_defs.svh"

module calib_regs (
  input  logic                            adc_clk,
  input  logic                            top_rst,
  sys_bus_if.slave                        bus,
  output pitaya_dsp_pkg::cal_cfg_t [1:0]  adc_cfg_o, // [0] is channel A
  output pitaya_dsp_pkg::cal_cfg_t [1:0]  dac_cfg_o
);

  // unity gain, no offset
  localparam pitaya_dsp_pkg::cal_cfg_t CFG_UNITY = '{
    gain:   pitaya_dsp_pkg::gain_t'(1 << `PITAYA_GAIN_FRAC),
    offset: '0
  };

  pitaya_bus_pkg::cal_reg_e  off;
  pitaya_bus_pkg::bus_word_t rd_val;
  logic                      hit;

  // sign extension to a bus word
  function automatic pitaya_bus_pkg::bus_word_t gain_word(pitaya_dsp_pkg::gain_t g);
    return {{(`PITAYA_ADW-`PITAYA_GDW){g[`PITAYA_GDW-1]}}, g};
  endfunction

  function automatic pitaya_bus_pkg::bus_word_t offs_word(pitaya_dsp_pkg::offset_t o);
    return {{(`PITAYA_ADW-`PITAYA_SDW){o[`PITAYA_SDW-1]}}, o};
  endfunction

  assign off = pitaya_bus_pkg::cal_reg_e'(bus.addr[`PITAYA_REGION_LSB-1:0]);

  //////////////////////////////
  // read-back
  //////////////////////////////

  always_comb
  begin
    rd_val = '0;
    hit    = 1'b1;
    case (off)
      pitaya_bus_pkg::CAL_ADC_A_GAIN: rd_val = gain_word(adc_cfg_o[0].gain);
      pitaya_bus_pkg::CAL_ADC_A_OFFS: rd_val = offs_word(adc_cfg_o[0].offset);
      pitaya_bus_pkg::CAL_ADC_B_GAIN: rd_val = gain_word(adc_cfg_o[1].gain);
      pitaya_bus_pkg::CAL_ADC_B_OFFS: rd_val = offs_word(adc_cfg_o[1].offset);
      pitaya_bus_pkg::CAL_DAC_A_GAIN: rd_val = gain_word(dac_cfg_o[0].gain);
      pitaya_bus_pkg::CAL_DAC_A_OFFS: rd_val = offs_word(dac_cfg_o[0].offset);
      pitaya_bus_pkg::CAL_DAC_B_GAIN: rd_val = gain_word(dac_cfg_o[1].gain);
      pitaya_bus_pkg::CAL_DAC_B_OFFS: rd_val = offs_word(dac_cfg_o[1].offset);
      default:                        hit    = 1'b0;
    endcase
  end

  //////////////////////////////
  // writes, upper bits dropped
  //////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
    begin
      adc_cfg_o <= {CFG_UNITY, CFG_UNITY};
      dac_cfg_o <= {CFG_UNITY, CFG_UNITY};
    end
    else if (bus.wen)
    begin
      case (off)
        pitaya_bus_pkg::CAL_ADC_A_GAIN: adc_cfg_o[0].gain   <= bus.wdata[`PITAYA_GDW-1:0];
        pitaya_bus_pkg::CAL_ADC_A_OFFS: adc_cfg_o[0].offset <= bus.wdata[`PITAYA_SDW-1:0];
        pitaya_bus_pkg::CAL_ADC_B_GAIN: adc_cfg_o[1].gain   <= bus.wdata[`PITAYA_GDW-1:0];
        pitaya_bus_pkg::CAL_ADC_B_OFFS: adc_cfg_o[1].offset <= bus.wdata[`PITAYA_SDW-1:0];
        pitaya_bus_pkg::CAL_DAC_A_GAIN: dac_cfg_o[0].gain   <= bus.wdata[`PITAYA_GDW-1:0];
        pitaya_bus_pkg::CAL_DAC_A_OFFS: dac_cfg_o[0].offset <= bus.wdata[`PITAYA_SDW-1:0];
        pitaya_bus_pkg::CAL_DAC_B_GAIN: dac_cfg_o[1].gain   <= bus.wdata[`PITAYA_GDW-1:0];
        pitaya_bus_pkg::CAL_DAC_B_OFFS: dac_cfg_o[1].offset <= bus.wdata[`PITAYA_SDW-1:0];
        default: ; // flagged in the response
      endcase
    end
  end

  // registered response, err on unknown offset
  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
    begin
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
      bus.rdata <= '0;
    end
    else
    begin
      bus.ack   <= bus.wen | bus.ren;
      bus.err   <= (bus.wen | bus.ren) & ~hit;
      bus.rdata <= (bus.ren && hit) ? rd_val : '0;
    end
  end

endmodule

// File: design/linear_cal.sv
// Gain and offset calibration
`timescale 1ns/1ps
`include "pitaya_defs.svh"

module linear_cal (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  input  pitaya_dsp_pkg::sample_t  dat_i,
  input  pitaya_dsp_pkg::cal_cfg_t cfg_i,
  output pitaya_dsp_pkg::sample_t  dat_o
);

  localparam int MW = `PITAYA_SDW + `PITAYA_GDW;  // full product
  localparam int SW = MW - `PITAYA_GAIN_FRAC + 1; // scaled plus offset, one guard bit

  logic signed [MW-1:0]    mul; // stage one
  logic signed [SW-1:0]    sum;
  pitaya_dsp_pkg::sample_t sat;

  // drop the fraction, then add the offset
  assign sum = SW'(mul >>> `PITAYA_GAIN_FRAC) + SW'($signed(cfg_i.offset));

  // clip to -8192..8191
  always_comb
  begin
    if (sum[SW-1:`PITAYA_SDW-1] != {(SW-`PITAYA_SDW+1){sum[SW-1]}})
      sat = {sum[SW-1], {(`PITAYA_SDW-1){~sum[SW-1]}}}; // overflow
    else
      sat = sum[`PITAYA_SDW-1:0];
  end

  //////////////////////////////
  // two register stages
  //////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
    begin
      mul   <= '0;
      dat_o <= '0;
    end
    else
    begin
      mul   <= dat_i * $signed(cfg_i.gain); // signed 14x16
      dat_o <= sat;
    end
  end

endmodule

// File: design/analog_front.sv
// ADC and DAC data path
`timescale 1ns/1ps
`include "pitaya_defs.svh"

module analog_front (
  input  logic                           adc_clk,
  input  logic                           top_rst,
  // pins, negative-slope offset binary
  input  logic [`PITAYA_SDW-1:0]         adc_raw_a_i,
  input  logic [`PITAYA_SDW-1:0]         adc_raw_b_i,
  // generator samples
  input  pitaya_dsp_pkg::sample_t        dac_dat_a_i,
  input  pitaya_dsp_pkg::sample_t        dac_dat_b_i,
  input  logic                           loop_en_i,
  input  pitaya_dsp_pkg::cal_cfg_t [1:0] adc_cfg_i,
  input  pitaya_dsp_pkg::cal_cfg_t [1:0] dac_cfg_i,
  // calibrated samples toward acquisition
  output pitaya_dsp_pkg::sample_t        adc_dat_a_o,
  output pitaya_dsp_pkg::sample_t        adc_dat_b_o,
  output logic [`PITAYA_SDW-1:0]         dac_raw_a_o,
  output logic [`PITAYA_SDW-1:0]         dac_raw_b_o
);

  // MSB kept, rest inverted, same rule both ways
  function automatic logic [`PITAYA_SDW-1:0] nsob_flip(logic [`PITAYA_SDW-1:0] v);
    return {v[`PITAYA_SDW-1], ~v[`PITAYA_SDW-2:0]};
  endfunction

  logic [`PITAYA_SDW-1:0]  adc_raw [2];
  pitaya_dsp_pkg::sample_t adc_in  [2]; // input register
  pitaya_dsp_pkg::sample_t adc_mux [2]; // pins or loopback
  pitaya_dsp_pkg::sample_t adc_cal [2];
  pitaya_dsp_pkg::sample_t dac_in  [2];
  pitaya_dsp_pkg::sample_t dac_cal [2];
  logic [`PITAYA_SDW-1:0]  dac_out [2]; // output register

  assign adc_raw[0] = adc_raw_a_i;
  assign adc_raw[1] = adc_raw_b_i;
  assign dac_in[0]  = dac_dat_a_i;
  assign dac_in[1]  = dac_dat_b_i;

  assign adc_dat_a_o = adc_cal[0];
  assign adc_dat_b_o = adc_cal[1];
  assign dac_raw_a_o = dac_out[0];
  assign dac_raw_b_o = dac_out[1];

  //////////////////////////////
  // per channel path
  //////////////////////////////

  for (genvar ch = 0; ch < 2; ch++)
  begin : g_ch
    always_ff @(posedge adc_clk, posedge top_rst)
    begin
      if (top_rst)
      begin
        adc_in[ch]  <= '0;
        dac_out[ch] <= '0;
      end
      else
      begin
        adc_in[ch]  <= nsob_flip(adc_raw[ch]); // to two's complement
        dac_out[ch] <= nsob_flip(dac_cal[ch]); // back to pin format
      end
    end

    // loopback takes the calibrated DAC stream
    assign adc_mux[ch] = loop_en_i ? dac_cal[ch] : adc_in[ch];

    linear_cal u_dac_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (dac_in[ch]),
      .cfg_i   (dac_cfg_i[ch]),
      .dat_o   (dac_cal[ch])
    );

    linear_cal u_adc_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (adc_mux[ch]),
      .cfg_i   (adc_cfg_i[ch]),
      .dat_o   (adc_cal[ch])
    );
  end

endmodule

// File: design/pitaya_core_top.sv
// Acquisition core top level
`timescale 1ns/1ps
`include "pitaya_defs.svh"

module pitaya_core_top (
  input  logic                    adc_clk,
  input  logic                    top_rst,
  // system bus
  input  logic [`PITAYA_ADW-1:0]  sys_addr_i,
  input  logic [`PITAYA_ADW-1:0]  sys_wdata_i,
  input  logic                    sys_wen_i,
  input  logic                    sys_ren_i,
  output logic [`PITAYA_ADW-1:0]  sys_rdata_o,
  output logic                    sys_err_o,
  output logic                    sys_ack_o,
  output logic [7:0]              led_o,
  // ADC pins and calibrated samples
  input  logic [`PITAYA_SDW-1:0]  adc_dat_a_i,
  input  logic [`PITAYA_SDW-1:0]  adc_dat_b_i,
  output pitaya_dsp_pkg::sample_t adc_dat_a_o,
  output pitaya_dsp_pkg::sample_t adc_dat_b_o,
  // generator samples and DAC pins
  input  pitaya_dsp_pkg::sample_t dac_dat_a_i,
  input  pitaya_dsp_pkg::sample_t dac_dat_b_i,
  output logic [`PITAYA_SDW-1:0]  dac_dat_a_o,
  output logic [`PITAYA_SDW-1:0]  dac_dat_b_o
);

  logic                           loop_en;
  pitaya_dsp_pkg::cal_cfg_t [1:0] adc_cfg;
  pitaya_dsp_pkg::cal_cfg_t [1:0] dac_cfg;

  sys_bus_if hk_bus ();  // region 0
  sys_bus_if cal_bus (); // region 1

  sys_bus_decoder u_decoder (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .m_addr_i  (sys_addr_i),
    .m_wdata_i (sys_wdata_i),
    .m_wen_i   (sys_wen_i),
    .m_ren_i   (sys_ren_i),
    .m_rdata_o (sys_rdata_o),
    .m_err_o   (sys_err_o),
    .m_ack_o   (sys_ack_o),
    .hk_bus    (hk_bus.decoder),
    .cal_bus   (cal_bus.decoder)
  );

  housekeeping u_hk (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .bus       (hk_bus.slave),
    .loop_en_o (loop_en),
    .led_o     (led_o)
  );

  calib_regs u_calib (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .bus       (cal_bus.slave),
    .adc_cfg_o (adc_cfg),
    .dac_cfg_o (dac_cfg)
  );

  analog_front u_analog (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_raw_a_i (adc_dat_a_i),
    .adc_raw_b_i (adc_dat_b_i),
    .dac_dat_a_i (dac_dat_a_i),
    .dac_dat_b_i (dac_dat_b_i),
    .loop_en_i   (loop_en),
    .adc_cfg_i   (adc_cfg),
    .dac_cfg_i   (dac_cfg),
    .adc_dat_a_o (adc_dat_a_o),
    .adc_dat_b_o (adc_dat_b_o),
    .dac_raw_a_o (dac_dat_a_o),
    .dac_raw_b_o (dac_dat_b_o)
  );

endmodule

// File: tests/tb_pitaya_core.sv
// Acquisition core testbench
`timescale 1ns/1ps
`include "pitaya_defs.svh"

module tb_pitaya_core;

  localparam int          ACK_WAIT = 20;             // cycles before a bus timeout
  localparam int          RUN_LEN  = 400;            // samples per stream phase
  localparam logic [31:0] CAL_BASE = 32'h0010_0000;  // region 1
  localparam logic [13:0] FLIP     = 14'h1FFF;       // pin format, low bits inverted

  logic              adc_clk;
  logic              top_rst;
  logic [31:0]       sys_addr;
  logic [31:0]       sys_wdata;
  logic              sys_wen;
  logic              sys_ren;
  logic [31:0]       sys_rdata;
  logic              sys_err;
  logic              sys_ack;
  logic [7:0]        led;
  logic [1:0][13:0]  adc_pin;  // [0] is channel A
  logic [1:0][13:0]  adc_out;
  logic [1:0][13:0]  dac_in;
  logic [1:0][13:0]  dac_pin;

  // model state
  logic [15:0] m_gain [4];  // ADC A, ADC B, DAC A, DAC B
  logic [13:0] m_offs [4];
  logic        m_loop;
  logic [7:0]  m_led;
  logic [13:0] h_dac [2][RUN_LEN]; // stimulus history
  logic [13:0] h_adc [2][RUN_LEN];
  logic [31:0] rng;
  int          err_cnt;

  pitaya_core_top u_dut (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_err_o   (sys_err),
    .sys_ack_o   (sys_ack),
    .led_o       (led),
    .adc_dat_a_i (adc_pin[0]),
    .adc_dat_b_i (adc_pin[1]),
    .adc_dat_a_o (adc_out[0]),
    .adc_dat_b_o (adc_out[1]),
    .dac_dat_a_i (dac_in[0]),
    .dac_dat_b_i (dac_in[1]),
    .dac_dat_a_o (dac_pin[0]),
    .dac_dat_b_o (dac_pin[1])
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk; // 125 MHz
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_word(output logic [31:0] v);
    rng = xorshift32(rng);
    v   = rng;
  endtask

  // Q2.14 gain, floor by 2^14, add offset, clip to 14 bits
  function automatic logic [13:0] cal_model(input logic [13:0] x, input logic [15:0] g,
                                            input logic [13:0] o);
    longint p;
    longint y;
    p = longint'($signed(x)) * longint'($signed(g));
    y = (p >>> 14) + longint'($signed(o));
    if (y > 8191)
      y = 8191;
    else if (y < -8192)
      y = -8192;
    return y[13:0];
  endfunction

  // read-back word of calibration register k
  function automatic logic [31:0] cal_expect(input int k);
    logic [15:0] g;
    logic [13:0] o;
    g = m_gain[k / 2];
    o = m_offs[k / 2];
    if (k % 2 == 0)
      return {{16{g[15]}}, g};
    return {{18{o[13]}}, o};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
    if (act_v !== exp_v)
    begin
      err_cnt++;
      $display("MISMATCH %s expected %h actual %h", name, exp_v, act_v);
      $display("=== FAIL ===");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // starts and ends on a falling edge, one idle cycle after ack
  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int   waited;
    logic got;
    sys_addr  = addr;
    sys_wdata = wdata;
    sys_wen   = wr;
    sys_ren   = ~wr;
    got       = 1'b0;
    waited    = 0;
    while (!got)
    begin
      @(negedge adc_clk);
      if (sys_ack)
      begin
        got   = 1'b1;
        rdata = sys_rdata; // valid with ack
        err   = sys_err;
      end
      sys_wen = 1'b0; // strobe lasts one cycle
      sys_ren = 1'b0;
      waited++;
      if (!got && waited > ACK_WAIT)
      begin
        $display("timeout: no bus ack for address %h", addr);
        $display("=== FAIL ===");
        $fatal(1, "bus access did not complete");
      end
    end
    @(negedge adc_clk);
  endtask

  task automatic write_reg(input string name, input logic [31:0] addr,
                           input logic [31:0] data, input logic exp_err);
    logic [31:0] rd;
    logic        e;
    bus_access(1'b1, addr, data, rd, e);
    check_eq({name, " write err"}, {31'd0, exp_err}, {31'd0, e});
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] rd;
    logic        e;
    bus_access(1'b0, addr, 32'd0, rd, e);
    check_eq({name, " read err"}, {31'd0, exp_err}, {31'd0, e});
    check_eq(name, exp_data, rd);
  endtask

  task automatic program_cal(input string name);
    logic [31:0] w;
    for (int k = 0; k < 8; k++)
    begin
      draw_word(w);
      write_reg($sformatf("%s %0d", name, k), CAL_BASE + 32'(4 * k), w, 1'b0);
      if (k % 2 == 0)
        m_gain[k / 2] = w[15:0];  // upper bits dropped
      else
        m_offs[k / 2] = w[13:0];
    end
  endtask

  task automatic read_all_cal(input string name);
    for (int k = 0; k < 8; k++)
      read_check($sformatf("%s %0d", name, k), CAL_BASE + 32'(4 * k), cal_expect(k), 1'b0);
  endtask

  //////////////////////////////
  // streams, 3 or 4 cycles late
  //////////////////////////////

  task automatic run_stream(input string name, input logic loop_on);
    logic [31:0] r;
    logic [13:0] e;
    for (int n = 0; n < RUN_LEN; n++)
    begin
      for (int ch = 0; ch < 2; ch++)
      begin
        if (n >= 3) // DAC pins, back to offset binary
        begin
          e = cal_model(h_dac[ch][n - 3], m_gain[2 + ch], m_offs[2 + ch]) ^ FLIP;
          check_eq($sformatf("%s dac %0d n=%0d", name, ch, n), 32'(e), 32'(dac_pin[ch]));
        end
        if (!loop_on && n >= 3)
        begin
          e = cal_model(h_adc[ch][n - 3] ^ FLIP, m_gain[ch], m_offs[ch]);
          check_eq($sformatf("%s adc %0d n=%0d", name, ch, n), 32'(e), 32'(adc_out[ch]));
        end
        if (loop_on && n >= 4) // DAC calibration feeds ADC calibration
        begin
          e = cal_model(h_dac[ch][n - 4], m_gain[2 + ch], m_offs[2 + ch]);
          e = cal_model(e, m_gain[ch], m_offs[ch]);
          check_eq($sformatf("%s loop %0d n=%0d", name, ch, n), 32'(e), 32'(adc_out[ch]));
        end
      end
      draw_word(r);
      h_dac[0][n] = r[13:0];
      h_dac[1][n] = r[29:16];
      draw_word(r);
      h_adc[0][n] = r[13:0];
      h_adc[1][n] = r[29:16];
      for (int ch = 0; ch < 2; ch++)
      begin
        dac_in[ch]  = h_dac[ch][n];
        adc_pin[ch] = h_adc[ch][n];
      end
      @(negedge adc_clk);
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial
  begin
    logic [31:0] w;
    logic [31:0] w2;
    logic [2:0]  region;
    rng       = 32'd91;
    err_cnt   = 0;
    top_rst   = 1'b1;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    adc_pin   = '0;
    dac_in    = '0;
    m_loop    = 1'b0;
    m_led     = '0;
    for (int c = 0; c < 4; c++)
    begin
      m_gain[c] = 16'h4000; // unity
      m_offs[c] = '0;
    end
    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    top_rst = 1'b0;
    @(negedge adc_clk);

    // reset values
    read_check("id", 32'h0, `PITAYA_ID, 1'b0);
    read_check("loop reset", 32'h4, 32'd0, 1'b0);
    read_check("led reset", 32'h30, 32'd0, 1'b0);
    read_all_cal("cal reset");

    // random writes, truncated and extended on read-back
    for (int rep = 0; rep < 4; rep++)
    begin
      draw_word(w);
      write_reg("led", 32'h30, w, 1'b0);
      m_led = w[7:0];
      draw_word(w);
      write_reg("loop", 32'h4, w, 1'b0);
      m_loop = w[0];
      program_cal("cal write");
      read_check("led", 32'h30, {24'd0, m_led}, 1'b0);
      check_eq("led port", {24'd0, m_led}, {24'd0, led});
      read_check("loop", 32'h4, {31'd0, m_loop}, 1'b0);
      read_all_cal("cal read");
    end
    draw_word(w);
    write_reg("id write", 32'h0, w, 1'b0); // ignored
    read_check("id after write", 32'h0, `PITAYA_ID, 1'b0);

    // unused regions answer zero, unknown offsets flag err
    for (int rep = 0; rep < 6; rep++)
    begin
      draw_word(w);
      draw_word(w2);
      region = 3'(2 + w % 6);
      read_check("unused read", {9'd0, region, w2[19:0]}, 32'd0, 1'b0);
      write_reg("unused write", {9'd0, region, w2[19:0]}, w, 1'b0);
    end
    read_check("hk unknown", 32'h0000_0008, 32'd0, 1'b1);
    write_reg("hk unknown", 32'h0000_0034, 32'hFFFF_FFFF, 1'b1);
    read_check("cal unknown", CAL_BASE + 32'h20, 32'd0, 1'b1);
    write_reg("cal unknown", CAL_BASE + 32'h02, 32'hFFFF_FFFF, 1'b1);
    read_all_cal("cal after unknown");

    // data path, loopback off then on
    write_reg("loop off", 32'h4, 32'd0, 1'b0);
    program_cal("cal stream");
    run_stream("direct", 1'b0);
    write_reg("loop on", 32'h4, 32'd1, 1'b0);
    program_cal("cal loop");
    run_stream("loopback", 1'b1);

    if (err_cnt == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: pitaya_core_top.f
+incdir+include
design/pitaya_bus_pkg.sv
design/pitaya_dsp_pkg.sv
design/sys_bus_if.sv
design/sys_bus_decoder.sv
design/housekeeping.sv
design/calib_regs.sv
design/linear_cal.sv
design/analog_front.sv
design/pitaya_core_top.sv
tests/tb_pitaya_core.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the acquisition core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_pitaya_core -f pitaya_core_top.f -o tb_pitaya_core

# the log decides the result, not the exit status
./obj_dir/tb_pitaya_core > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
